//--- rtl/axi_pkg.sv
package axi_pkg;

    // Field widths of the simplified AXI channels
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int LEN_WIDTH  = 8;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int RESP_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [LEN_WIDTH-1:0]  len_t;
    typedef logic [RESP_WIDTH-1:0] resp_t;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

//--- rtl/id_remap_pkg.sv
package id_remap_pkg;

    localparam int ID_WIDTH_IN  = 6; // Manager side
    localparam int ID_WIDTH_OUT = 3; // Subordinate side

    // Slots per channel, at most 2**ID_WIDTH_OUT
    localparam int TABLE_SIZE = 4;

    // Keep at least one bit for a single-slot table
    localparam int IDX_WIDTH = (TABLE_SIZE > 1) ? $clog2(TABLE_SIZE) : 1;

    typedef logic [ID_WIDTH_IN-1:0]  id_in_t;
    typedef logic [ID_WIDTH_OUT-1:0] id_out_t;
    typedef logic [IDX_WIDTH-1:0]    idx_t;

endpackage

//--- rtl/id_remap_table.sv
`timescale 1ns/1ps

module id_remap_table (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 alloc_i,
    input  id_remap_pkg::id_in_t id_i,
    output id_remap_pkg::idx_t   free_idx_o,
    output logic                 full_o,

    input  logic                 release_i,
    input  id_remap_pkg::idx_t   rel_idx_i,
    output id_remap_pkg::id_in_t rel_id_o,
    output logic                 empty_o
);

    import id_remap_pkg::*;

    logic [TABLE_SIZE-1:0] valid_q;  // Slot in use
    id_in_t                id_q [TABLE_SIZE];
    idx_t                  free_idx;

    // Lowest free slot wins, so scan from the top down
    always_comb begin
        free_idx = '0;
        for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = idx_t'(i);
            end
        end
    end

    assign free_idx_o = free_idx;
    assign full_o     = &valid_q;   // No slot left
    assign empty_o    = ~(|valid_q);
    assign rel_id_o   = id_q[rel_idx_i];

    // Allocation and release may land in the same cycle on different slots
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                if (alloc_i && (free_idx == idx_t'(i))) begin
                    valid_q[i] <= 1'b1;
                end else if (release_i && (rel_idx_i == idx_t'(i))) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    // Original IDs, only meaningful while the valid bit is set
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            id_q[free_idx] <= id_i;
        end
    end

endmodule

//--- rtl/id_remap_channel.sv
`timescale 1ns/1ps

module id_remap_channel #(
    parameter bit RELEASE_ON_LAST = 1'b0  // Set for R, clear for B
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Upstream request
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  id_remap_pkg::id_in_t  req_id_i,

    // Downstream request
    output logic                  req_valid_o,
    input  logic                  req_ready_i,
    output id_remap_pkg::id_out_t req_id_o,

    // Downstream response
    input  logic                  rsp_valid_i,
    output logic                  rsp_ready_o,
    input  id_remap_pkg::id_out_t rsp_id_i,
    input  logic                  rsp_last_i,

    // Upstream response
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output id_remap_pkg::id_in_t  rsp_id_o
);

    import id_remap_pkg::*;

    logic full;
    logic empty;
    logic alloc;
    logic release_slot;
    idx_t free_idx;
    idx_t rel_idx;

    // Request side is held off while every slot is taken
    assign req_valid_o = req_valid_i & ~full;
    assign req_ready_o = req_ready_i & ~full;
    assign alloc       = req_valid_i & req_ready_i & ~full;
    assign req_id_o    = id_out_t'(free_idx);  // Zero extended slot index

    // Nothing outstanding means no response can be legal
    assign rsp_valid_o  = rsp_valid_i & ~empty;
    assign rsp_ready_o  = rsp_ready_i & ~empty;
    assign rel_idx      = rsp_id_i[IDX_WIDTH-1:0];
    assign release_slot = rsp_valid_i & rsp_ready_i & ~empty
                        & (rsp_last_i | ~RELEASE_ON_LAST);

    id_remap_table u_table (
        .clk_i      ( clk_i        ),
        .rst_ni     ( rst_ni       ),
        .alloc_i    ( alloc        ),
        .id_i       ( req_id_i     ),
        .free_idx_o ( free_idx     ),
        .full_o     ( full         ),
        .release_i  ( release_slot ),
        .rel_idx_i  ( rel_idx      ),
        .rel_id_o   ( rsp_id_o     ),
        .empty_o    ( empty        )
    );

endmodule

//--- rtl/axi_id_remap.sv
`timescale 1ns/1ps

module axi_id_remap (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Manager side
    input  logic                  s_aw_valid_i,
    output logic                  s_aw_ready_o,
    input  id_remap_pkg::id_in_t  s_aw_id_i,
    input  axi_pkg::addr_t        s_aw_addr_i,
    input  axi_pkg::len_t         s_aw_len_i,

    input  logic                  s_w_valid_i,
    output logic                  s_w_ready_o,
    input  axi_pkg::data_t        s_w_data_i,
    input  axi_pkg::strb_t        s_w_strb_i,
    input  logic                  s_w_last_i,

    output logic                  s_b_valid_o,
    input  logic                  s_b_ready_i,
    output id_remap_pkg::id_in_t  s_b_id_o,
    output axi_pkg::resp_t        s_b_resp_o,

    input  logic                  s_ar_valid_i,
    output logic                  s_ar_ready_o,
    input  id_remap_pkg::id_in_t  s_ar_id_i,
    input  axi_pkg::addr_t        s_ar_addr_i,
    input  axi_pkg::len_t         s_ar_len_i,

    output logic                  s_r_valid_o,
    input  logic                  s_r_ready_i,
    output id_remap_pkg::id_in_t  s_r_id_o,
    output axi_pkg::data_t        s_r_data_o,
    output axi_pkg::resp_t        s_r_resp_o,
    output logic                  s_r_last_o,

    // Subordinate side
    output logic                  m_aw_valid_o,
    input  logic                  m_aw_ready_i,
    output id_remap_pkg::id_out_t m_aw_id_o,
    output axi_pkg::addr_t        m_aw_addr_o,
    output axi_pkg::len_t         m_aw_len_o,

    output logic                  m_w_valid_o,
    input  logic                  m_w_ready_i,
    output axi_pkg::data_t        m_w_data_o,
    output axi_pkg::strb_t        m_w_strb_o,
    output logic                  m_w_last_o,

    input  logic                  m_b_valid_i,
    output logic                  m_b_ready_o,
    input  id_remap_pkg::id_out_t m_b_id_i,
    input  axi_pkg::resp_t        m_b_resp_i,

    output logic                  m_ar_valid_o,
    input  logic                  m_ar_ready_i,
    output id_remap_pkg::id_out_t m_ar_id_o,
    output axi_pkg::addr_t        m_ar_addr_o,
    output axi_pkg::len_t         m_ar_len_o,

    input  logic                  m_r_valid_i,
    output logic                  m_r_ready_o,
    input  id_remap_pkg::id_out_t m_r_id_i,
    input  axi_pkg::data_t        m_r_data_i,
    input  axi_pkg::resp_t        m_r_resp_i,
    input  logic                  m_r_last_i
);

    // Request payloads go through untouched
    assign m_aw_addr_o = s_aw_addr_i;
    assign m_aw_len_o  = s_aw_len_i;
    assign m_ar_addr_o = s_ar_addr_i;
    assign m_ar_len_o  = s_ar_len_i;

    // W carries no ID
    assign m_w_valid_o = s_w_valid_i;
    assign s_w_ready_o = m_w_ready_i;
    assign m_w_data_o  = s_w_data_i;
    assign m_w_strb_o  = s_w_strb_i;
    assign m_w_last_o  = s_w_last_i;

    assign s_b_resp_o = m_b_resp_i;
    assign s_r_data_o = m_r_data_i;
    assign s_r_resp_o = m_r_resp_i;
    assign s_r_last_o = m_r_last_i;

    // B is always a single beat, so every accepted response frees its slot
    id_remap_channel #(
        .RELEASE_ON_LAST ( 1'b0 )
    ) u_wr_chan (
        .clk_i       ( clk_i        ),
        .rst_ni      ( rst_ni       ),
        .req_valid_i ( s_aw_valid_i ),
        .req_ready_o ( s_aw_ready_o ),
        .req_id_i    ( s_aw_id_i    ),
        .req_valid_o ( m_aw_valid_o ),
        .req_ready_i ( m_aw_ready_i ),
        .req_id_o    ( m_aw_id_o    ),
        .rsp_valid_i ( m_b_valid_i  ),
        .rsp_ready_o ( m_b_ready_o  ),
        .rsp_id_i    ( m_b_id_i     ),
        .rsp_last_i  ( m_b_valid_i  ),
        .rsp_valid_o ( s_b_valid_o  ),
        .rsp_ready_i ( s_b_ready_i  ),
        .rsp_id_o    ( s_b_id_o     )
    );

    id_remap_channel #(
        .RELEASE_ON_LAST ( 1'b1 )
    ) u_rd_chan (
        .clk_i       ( clk_i        ),
        .rst_ni      ( rst_ni       ),
        .req_valid_i ( s_ar_valid_i ),
        .req_ready_o ( s_ar_ready_o ),
        .req_id_i    ( s_ar_id_i    ),
        .req_valid_o ( m_ar_valid_o ),
        .req_ready_i ( m_ar_ready_i ),
        .req_id_o    ( m_ar_id_o    ),
        .rsp_valid_i ( m_r_valid_i  ),
        .rsp_ready_o ( m_r_ready_o  ),
        .rsp_id_i    ( m_r_id_i     ),
        .rsp_last_i  ( m_r_last_i   ),
        .rsp_valid_o ( s_r_valid_o  ),
        .rsp_ready_i ( s_r_ready_i  ),
        .rsp_id_o    ( s_r_id_o     )
    );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a falling edge, clear of the stimulus edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- verification/tb_axi_id_remap.sv
`timescale 1ns/1ps

module tb_axi_id_remap;

    import axi_pkg::*;
    import id_remap_pkg::*;

    localparam int N_DIRECTED     = 40;  // Tests 1 to 5 together
    localparam int N_RANDOM       = 200;
    localparam int CYCLES_PER_TXN = 200;

    logic clk_i;
    logic rst_ni;

    // Manager-side DUT inputs
    logic   s_aw_valid_i = 1'b0, s_w_valid_i = 1'b0, s_w_last_i = 1'b0, s_ar_valid_i = 1'b0;
    logic   s_b_ready_i = 1'b0, s_r_ready_i = 1'b0;
    id_in_t s_aw_id_i = '0, s_ar_id_i = '0;
    addr_t  s_aw_addr_i = '0, s_ar_addr_i = '0;
    len_t   s_aw_len_i = '0, s_ar_len_i = '0;
    data_t  s_w_data_i = '0;
    strb_t  s_w_strb_i = '0;

    // Subordinate-side DUT inputs
    logic    m_aw_ready_i = 1'b0, m_w_ready_i = 1'b0, m_ar_ready_i = 1'b0;
    logic    m_b_valid_i = 1'b0, m_r_valid_i = 1'b0, m_r_last_i = 1'b0;
    id_out_t m_b_id_i = '0, m_r_id_i = '0;
    data_t   m_r_data_i = '0;
    resp_t   m_b_resp_i = '0, m_r_resp_i = '0;

    // DUT outputs
    logic    s_aw_ready_o, s_w_ready_o, s_b_valid_o, s_ar_ready_o, s_r_valid_o, s_r_last_o;
    id_in_t  s_b_id_o, s_r_id_o;
    data_t   s_r_data_o;
    resp_t   s_b_resp_o, s_r_resp_o;
    logic    m_aw_valid_o, m_w_valid_o, m_w_last_o, m_b_ready_o, m_ar_valid_o, m_r_ready_o;
    id_out_t m_aw_id_o, m_ar_id_o;
    addr_t   m_aw_addr_o, m_ar_addr_o;
    len_t    m_aw_len_o, m_ar_len_o;
    data_t   m_w_data_o;
    strb_t   m_w_strb_o;

    logic [31:0]           seed = 32'h126d;
    logic [TABLE_SIZE-1:0] wr_occ = '0;  // Occupancy model
    logic [TABLE_SIZE-1:0] rd_occ = '0;
    id_in_t                wr_orig [TABLE_SIZE];
    id_in_t                rd_orig [TABLE_SIZE];
    id_out_t               wr_q [$];  // Outstanding at the subordinate
    id_out_t               rd_q [$];
    len_t                  rd_len_q [$];
    bit                    hold_rsp  = 1'b1;
    bit                    rnd_ready = 1'b0;
    int                    errors    = 0;
    int                    checks    = 0;
    int                    err_start = 0;
    int                    test_num  = 0;
    int                    n_pass    = 0;
    int                    n_fail    = 0;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

    axi_id_remap dut_i (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic bit coin();
        logic [31:0] r;
        r = lcg_next();
        return r[16];
    endfunction

    // Expected output ID is the lowest free slot or -1 when none is left
    function automatic int lowest_free(input logic [TABLE_SIZE-1:0] occ);
        int idx;
        idx = -1;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            if (idx < 0 && !occ[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("error at %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    // Compares mid-cycle while inputs are settled
    always @(negedge clk_i) begin
        int   wr_exp;
        int   rd_exp;
        idx_t b_idx;
        idx_t r_idx;
        if (rst_ni) begin
            wr_exp = lowest_free(wr_occ);
            rd_exp = lowest_free(rd_occ);
            b_idx  = m_b_id_i[IDX_WIDTH-1:0];
            r_idx  = m_r_id_i[IDX_WIDTH-1:0];
            if (wr_exp < 0) begin
                check(!m_aw_valid_o && !s_aw_ready_o, "write request let through on a full table");
            end else begin
                check(m_aw_valid_o == s_aw_valid_i && s_aw_ready_o == m_aw_ready_i
                      && (!s_aw_valid_i || (m_aw_id_o == id_out_t'(wr_exp)
                      && m_aw_addr_o == s_aw_addr_i && m_aw_len_o == s_aw_len_i)),
                      $sformatf("aw id %0d, expected %0d", m_aw_id_o, wr_exp));
            end
            if (rd_exp < 0) begin
                check(!m_ar_valid_o && !s_ar_ready_o, "read request let through on a full table");
            end else begin
                check(m_ar_valid_o == s_ar_valid_i && s_ar_ready_o == m_ar_ready_i
                      && (!s_ar_valid_i || (m_ar_id_o == id_out_t'(rd_exp)
                      && m_ar_addr_o == s_ar_addr_i && m_ar_len_o == s_ar_len_i)),
                      $sformatf("ar id %0d, expected %0d", m_ar_id_o, rd_exp));
            end
            check(s_b_valid_o == (m_b_valid_i && |wr_occ)
                  && m_b_ready_o == (s_b_ready_i && |wr_occ)
                  && (!m_b_valid_i || (s_b_id_o == wr_orig[b_idx] && s_b_resp_o == m_b_resp_i)),
                  $sformatf("b id %0d, expected %0d", s_b_id_o, wr_orig[b_idx]));
            check(s_r_valid_o == (m_r_valid_i && |rd_occ)
                  && m_r_ready_o == (s_r_ready_i && |rd_occ)
                  && (!m_r_valid_i || (s_r_id_o == rd_orig[r_idx] && s_r_data_o == m_r_data_i
                  && s_r_resp_o == m_r_resp_i && s_r_last_o == m_r_last_i)),
                  $sformatf("r id %0d, expected %0d", s_r_id_o, rd_orig[r_idx]));
            check(m_w_valid_o == s_w_valid_i && s_w_ready_o == m_w_ready_i
                  && m_w_data_o == s_w_data_i && m_w_strb_o == s_w_strb_i
                  && m_w_last_o == s_w_last_i, "write data beat altered on its way through");

            // Model moves with the handshakes about to complete
            if (m_b_valid_i && m_b_ready_o) begin
                wr_occ[b_idx] = 1'b0;
            end
            if (m_r_valid_i && m_r_ready_o && m_r_last_i) begin
                rd_occ[r_idx] = 1'b0;
            end
            if (s_aw_valid_i && s_aw_ready_o && wr_exp >= 0) begin
                wr_occ[idx_t'(wr_exp)]  = 1'b1;
                wr_orig[idx_t'(wr_exp)] = s_aw_id_i;
            end
            if (s_ar_valid_i && s_ar_ready_o && rd_exp >= 0) begin
                rd_occ[idx_t'(rd_exp)]  = 1'b1;
                rd_orig[idx_t'(rd_exp)] = s_ar_id_i;
            end
        end
    end

    // Subordinate model answering in random order
    initial begin
        bit      aw_hs, ar_hs, b_hs, r_hs;
        id_out_t aw_id, ar_id;
        len_t    ar_len;
        int      k;
        int      beats_left;
        beats_left = 0;
        forever begin
            @(negedge clk_i);
            aw_hs  = m_aw_valid_o && m_aw_ready_i;
            ar_hs  = m_ar_valid_o && m_ar_ready_i;
            b_hs   = m_b_valid_i && m_b_ready_o;
            r_hs   = m_r_valid_i && m_r_ready_o;
            aw_id  = m_aw_id_o;
            ar_id  = m_ar_id_o;
            ar_len = m_ar_len_o;
            @(posedge clk_i);
            if (aw_hs) begin
                wr_q.push_back(aw_id);
            end
            if (ar_hs) begin
                rd_q.push_back(ar_id);
                rd_len_q.push_back(ar_len);
            end
            m_aw_ready_i <= rnd_ready ? coin() : 1'b1;
            m_ar_ready_i <= rnd_ready ? coin() : 1'b1;
            m_w_ready_i  <= rnd_ready ? coin() : 1'b1;
            s_b_ready_i  <= rnd_ready ? coin() : 1'b1;
            s_r_ready_i  <= rnd_ready ? coin() : 1'b1;
            if (b_hs || !m_b_valid_i) begin
                if (!hold_rsp && wr_q.size() > 0 && coin()) begin
                    k = int'(lcg_next() % wr_q.size());
                    m_b_id_i    <= wr_q[k];
                    m_b_resp_i  <= coin() ? RESP_SLVERR : RESP_OKAY;
                    m_b_valid_i <= 1'b1;
                    wr_q.delete(k);
                end else begin
                    m_b_valid_i <= 1'b0;
                end
            end
            if (r_hs && beats_left > 0) begin
                beats_left--;  // Next beat of the same burst
                m_r_data_i <= lcg_next();
                m_r_last_i <= (beats_left == 0);
            end else if (r_hs || !m_r_valid_i) begin
                if (!hold_rsp && rd_q.size() > 0 && coin()) begin
                    k = int'(lcg_next() % rd_q.size());
                    beats_left  = int'(rd_len_q[k]);
                    m_r_id_i    <= rd_q[k];
                    m_r_data_i  <= lcg_next();
                    m_r_resp_i  <= coin() ? RESP_SLVERR : RESP_OKAY;
                    m_r_last_i  <= (beats_left == 0);
                    m_r_valid_i <= 1'b1;
                    rd_q.delete(k);
                    rd_len_q.delete(k);
                end else begin
                    m_r_valid_i <= 1'b0;
                end
            end
        end
    end

    task automatic send_aw(input id_in_t id, input len_t len);
        @(posedge clk_i);
        s_aw_valid_i <= 1'b1;
        s_aw_id_i    <= id;
        s_aw_addr_i  <= lcg_next();
        s_aw_len_i   <= len;
        @(negedge clk_i);
        while (!s_aw_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        s_aw_valid_i <= 1'b0;
    endtask

    task automatic send_ar(input id_in_t id, input len_t len);
        @(posedge clk_i);
        s_ar_valid_i <= 1'b1;
        s_ar_id_i    <= id;
        s_ar_addr_i  <= lcg_next();
        s_ar_len_i   <= len;
        @(negedge clk_i);
        while (!s_ar_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        s_ar_valid_i <= 1'b0;
    endtask

    task automatic send_w(input bit last);
        @(posedge clk_i);
        s_w_valid_i <= 1'b1;
        s_w_data_i  <= lcg_next();
        s_w_strb_i  <= strb_t'(lcg_next());
        s_w_last_i  <= last;
        @(negedge clk_i);
        while (!s_w_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        s_w_valid_i <= 1'b0;
    endtask

    // Model is updated on falling edges, so look at it on rising ones
    task automatic wait_drain();
        @(posedge clk_i);
        while (wr_occ != '0 || rd_occ != '0) @(posedge clk_i);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_start) begin
            n_pass++;
            $display("test %0d %s: PASS", test_num, name);
        end else begin
            n_fail++;
            $display("test %0d %s: FAIL with %0d errors", test_num, name, errors - err_start);
        end
        err_start = errors;
    endtask

    initial begin
        @(posedge rst_ni);
        for (int i = 0; i < TABLE_SIZE; i++) begin
            send_aw(id_in_t'(7 * i + 3), len_t'(i));
        end
        for (int i = 0; i < TABLE_SIZE; i++) begin
            send_ar(id_in_t'(5 * i + 40), '0);
        end
        end_test("ids in allocation order");

        hold_rsp <= 1'b0;
        wait_drain();
        end_test("original ids returned");

        hold_rsp <= 1'b1;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            send_aw(id_in_t'(i + 20), '0);
        end
        fork
            send_aw(id_in_t'(63), '0);
            begin
                repeat (10) @(posedge clk_i);
                hold_rsp <= 1'b0;
            end
        join
        wait_drain();
        end_test("full table back-pressure");

        hold_rsp <= 1'b1;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            send_ar(id_in_t'(9), len_t'(3));  // Same original ID on every slot
        end
        fork
            send_ar(id_in_t'(33), len_t'(2));
            begin
                repeat (10) @(posedge clk_i);
                hold_rsp <= 1'b0;
            end
        join
        wait_drain();
        end_test("read bursts hold their slot");

        rnd_ready <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_w(i % 4 == 3);
        end
        end_test("write data pass-through");

        fork
            for (int i = 0; i < N_RANDOM / 2; i++) begin
                len_t len;
                len = len_t'(lcg_next() % 4);
                send_aw(id_in_t'(lcg_next()), len);
                for (int j = 0; j <= int'(len); j++) begin
                    send_w(j == int'(len));
                end
            end
            for (int i = 0; i < N_RANDOM / 2; i++) begin
                send_ar(id_in_t'(lcg_next()), len_t'(lcg_next() % 4));
            end
        join
        wait_drain();
        end_test("random mix");

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 n_pass, n_fail, checks, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat ((N_DIRECTED + N_RANDOM) * CYCLES_PER_TXN) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles",
                 (N_DIRECTED + N_RANDOM) * CYCLES_PER_TXN);
        $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
rtl/axi_pkg.sv
rtl/id_remap_pkg.sv
rtl/id_remap_table.sv
rtl/id_remap_channel.sv
rtl/axi_id_remap.sv
verification/tb_clk_gen.sv
verification/tb_axi_id_remap.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_id_remap
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

$(EXE): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

build: $(EXE)

# Pass or fail comes from the log, a crash counts as a failure too
run: build
	@./$(EXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
